/* source/cmul_pkg.sv */
/* widths, pipeline depth and the sample, complex, product and accumulator
   types shared by the complex multiplier */
package cmul_pkg;

  // one real or imaginary part
  localparam int data_w = 18;

  // a*b +/- c*d at full precision, one growth bit for the sum
  localparam int prod_w = 2 * data_w + 1;

  // result width of the multiply-accumulate block
  localparam int acc_w = 41;

  // enabled edges from operands at the ports to the rounded result
  // two in the first mac, one in the cascaded mac, one in the rounder
  localparam int pipe_depth = 4;

  // signed fixed-point sample
  typedef logic signed [data_w-1:0] sample_t;

  // complex sample, real part in the upper half
  typedef struct packed {
    sample_t re;
    sample_t im;
  } cplx_t;

  // full precision half product before rounding
  typedef logic signed [prod_w-1:0] prod_t;

  // accumulator and cascade path of the mac block
  typedef logic signed [acc_w-1:0] acc_t;

endpackage

/* source/mac_stage.sv */
/* registered multiply-accumulate stage modeled on an 18x18 DSP block,
   with optional cascade input and subtract */
module mac_stage #(
  // cascade set: p = carry_in +/- a*b, else p = a*b
  parameter bit cascade  = 1'b0,
  // only meaningful with cascade set
  parameter bit subtract = 1'b0
) (
  input  logic              clk,
  input  logic              rst,
  input  logic              clk_en,
  input  cmul_pkg::sample_t mcand_a,
  input  cmul_pkg::sample_t mcand_b,
  input  cmul_pkg::acc_t    carry_in,
  output cmul_pkg::acc_t    p_out
);
  import cmul_pkg::*;

  sample_t a_reg;
  sample_t b_reg;
  acc_t    prod;
  acc_t    p_next;
  acc_t    p_reg;

  // input registers of the block, first enabled edge
  always_ff @(posedge clk) begin
    if (rst) begin
      a_reg <= '0;
      b_reg <= '0;
    end else if (clk_en) begin
      a_reg <= mcand_a;
      b_reg <= mcand_b;
    end
  end

  // signed 18x18 multiply
  // both operands sign extended so the product lands in acc width
  assign prod = acc_t'(a_reg) * acc_t'(b_reg);

  // post-adder on the cascade path
  always_comb begin
    if (!cascade) begin
      p_next = prod;
    end else if (subtract) begin
      p_next = carry_in - prod;
    end else begin
      p_next = carry_in + prod;
    end
  end

  // product register, second enabled edge
  always_ff @(posedge clk) begin
    if (rst) begin
      p_reg <= '0;
    end else if (clk_en) begin
      p_reg <= p_next;
    end
  end

  // p_out also serves as the cascade output to the next stage
  assign p_out = p_reg;

endmodule

/* source/half_product.sv */
/* half of the complex product, a*b - c*d or a*b + c*d, from two cascaded
   mac stages with the c/d alignment delay and truncation to prod_w bits */
module half_product #(
  // one gives a*b - c*d, zero gives a*b + c*d
  parameter bit minus = 1'b1
) (
  input  logic              clk,
  input  logic              rst,
  input  logic              clk_en,
  input  cmul_pkg::sample_t a,
  input  cmul_pkg::sample_t b,
  input  cmul_pkg::sample_t c,
  input  cmul_pkg::sample_t d,
  output cmul_pkg::prod_t   half_prod
);
  import cmul_pkg::*;

  // second operand pair, delayed as one word
  typedef struct packed {
    sample_t c;
    sample_t d;
  } cd_pair_t;

  cd_pair_t cd_dly;
  acc_t     ab_acc;
  acc_t     sum_acc;

  // c and d go one enabled edge behind a and b, so the second
  // stage sees its operands when the first product is registered
  always_ff @(posedge clk) begin
    if (rst) begin
      cd_dly <= '0;
    end else if (clk_en) begin
      cd_dly <= {c, d};
    end
  end

  // a*b, nothing to add yet
  mac_stage #(
    .cascade  (1'b0),
    .subtract (1'b0)
  ) i_mac_ab (
    .clk      (clk),
    .rst      (rst),
    .clk_en   (clk_en),
    .mcand_a  (a),
    .mcand_b  (b),
    .carry_in ('0),
    .p_out    (ab_acc)
  );

  // a*b -/+ c*d, ready three enabled edges after a, b, c, d were sampled
  mac_stage #(
    .cascade  (1'b1),
    .subtract (minus)
  ) i_mac_cd (
    .clk      (clk),
    .rst      (rst),
    .clk_en   (clk_en),
    .mcand_a  (cd_dly.c),
    .mcand_b  (cd_dly.d),
    .carry_in (ab_acc),
    .p_out    (sum_acc)
  );

  // the sum of two 18x18 products fits in prod_w bits
  // everything above is a copy of the sign
  assign half_prod = sum_acc[prod_w-1:0];

endmodule

/* source/round_half_up.sv */
/* registered rounding of a full precision half product to data_w bits,
   half toward plus infinity, no saturation */
module round_half_up (
  input  logic              clk,
  input  logic              rst,
  input  logic              clk_en,
  input  cmul_pkg::prod_t   full,
  output cmul_pkg::sample_t rounded
);
  import cmul_pkg::*;

  logic [data_w:0]   kept;
  logic [data_w-1:0] sum;

  // top bit of full only repeats the one below it, drop it
  // and keep one bit under the output lsb for rounding
  assign kept = full[2*data_w-1:data_w-1];

  // add the half bit into the upper data_w bits
  // exact halves go up for both signs
  assign sum = kept[data_w:1] + {{(data_w-1){1'b0}}, kept[0]};

  // output register
  always_ff @(posedge clk) begin
    if (rst) begin
      rounded <= '0;
    end else if (clk_en) begin
      rounded <= sum;
    end
  end

endmodule

/* source/cmplx_mult.sv */
/* pipelined signed complex multiplier h = q*t for FFT butterflies,
   two half products and two rounders, four enabled edges deep */
module cmplx_mult (
  input  logic            clk,
  input  logic            rst,
  input  logic            clk_en,
  input  cmul_pkg::cplx_t q,
  input  cmul_pkg::cplx_t t,
  output cmul_pkg::cplx_t h
);
  import cmul_pkg::*;

  prod_t   re_full;
  prod_t   im_full;
  sample_t re_rnd;
  sample_t im_rnd;

  // real part q.re*t.re - q.im*t.im
  half_product #(
    .minus (1'b1)
  ) i_half_re (
    .clk       (clk),
    .rst       (rst),
    .clk_en    (clk_en),
    .a         (q.re),
    .b         (t.re),
    .c         (q.im),
    .d         (t.im),
    .half_prod (re_full)
  );

  // imaginary part q.im*t.re + q.re*t.im
  half_product #(
    .minus (1'b0)
  ) i_half_im (
    .clk       (clk),
    .rst       (rst),
    .clk_en    (clk_en),
    .a         (q.im),
    .b         (t.re),
    .c         (q.re),
    .d         (t.im),
    .half_prod (im_full)
  );

  // back to data_w bits, one more enabled edge
  round_half_up i_rnd_re (
    .clk     (clk),
    .rst     (rst),
    .clk_en  (clk_en),
    .full    (re_full),
    .rounded (re_rnd)
  );

  round_half_up i_rnd_im (
    .clk     (clk),
    .rst     (rst),
    .clk_en  (clk_en),
    .full    (im_full),
    .rounded (im_rnd)
  );

  assign h.re = re_rnd;
  assign h.im = im_rnd;

endmodule

/* bench/cmplx_checker.sv */
/* result checker for the complex multiplier, queues the expected product
   of every accepted input and compares it with h pipe_depth enabled edges later */
module cmplx_checker (
  input  logic            clk,
  input  logic            rst,
  input  logic            clk_en,
  input  cmul_pkg::cplx_t q,
  input  cmul_pkg::cplx_t t,
  input  cmul_pkg::cplx_t h,
  input  logic            exp_valid,
  input  logic [7:0]      exp_test,
  input  logic            exp_last,
  input  cmul_pkg::cplx_t exp_h,
  output int              pass_cnt,
  output int              fail_cnt,
  output int              pending_cnt
);
  import cmul_pkg::*;

  // one accepted input and the result it should give
  typedef struct packed {
    int         stamp;
    logic [7:0] test_no;
    logic       last;
    cplx_t      q;
    cplx_t      t;
    cplx_t      h;
  } expect_t;

  expect_t pending [$];
  expect_t entry;
  int      en_edges;
  int      test_checks;
  int      test_errors;
  int      reset_checks;
  int      reset_errors;
  logic    first_seen;

  // oldest entry has gone through pipe_depth enabled edges
  function automatic logic head_ready();
    if (pending.size() == 0) begin
      return 1'b0;
    end
    return (en_edges - pending[0].stamp) >= pipe_depth;
  endfunction

  // nothing has come out yet, so h still holds the reset value
  task automatic check_idle_zero();
    reset_checks++;
    if (h !== '0) begin
      reset_errors++;
      fail_cnt++;
      $display("ERR %0t: h = (%0d, %0d) before the first result, expected zero",
               $time, h.re, h.im);
    end else begin
      pass_cnt++;
    end
  endtask

  task automatic compare_head();
    expect_t e;
    e = pending.pop_front();
    test_checks++;
    if (h !== e.h) begin
      test_errors++;
      fail_cnt++;
      $display("ERR %0t: test %0d q = (%0d, %0d) t = (%0d, %0d)",
               $time, e.test_no, e.q.re, e.q.im, e.t.re, e.t.im);
      $display("ERR %0t: expected h = (%0d, %0d), got h = (%0d, %0d)",
               $time, e.h.re, e.h.im, h.re, h.im);
    end else begin
      pass_cnt++;
    end
    if (e.last) begin
      $display("test %0d done with %0d results checked and %0d wrong",
               e.test_no, test_checks, test_errors);
      test_checks = 0;
      test_errors = 0;
    end
  endtask

  // h is read before this edge updates it
  always @(posedge clk) begin
    if (rst) begin
      pending.delete();
      en_edges     = 0;
      test_checks  = 0;
      test_errors  = 0;
      reset_checks = 0;
      reset_errors = 0;
      first_seen   = 1'b0;
      pass_cnt     = 0;
      fail_cnt     = 0;
      pending_cnt  = 0;
    end else begin
      if (!first_seen && !head_ready()) begin
        check_idle_zero();
      end
      if (clk_en) begin
        if (head_ready()) begin
          if (!first_seen) begin
            $display("reset done with %0d edges checked and %0d wrong",
                     reset_checks, reset_errors);
            first_seen = 1'b1;
          end
          compare_head();
        end
        if (exp_valid) begin
          entry.stamp   = en_edges;
          entry.test_no = exp_test;
          entry.last    = exp_last;
          entry.q       = q;
          entry.t       = t;
          entry.h       = exp_h;
          pending.push_back(entry);
        end
        en_edges++;
      end
      pending_cnt = pending.size();
    end
  end

endmodule

/* bench/tb_cmplx_mult.sv */
/* testbench for the complex multiplier, reads vectors from the data file
   and drives them on the falling edge, with timeout and closing summary */
module tb_cmplx_mult;
  import cmul_pkg::*;

  // eight words per vector in the data file
  localparam int vec_words = 8;
  localparam int max_vec   = 128;

  logic        clk;
  logic        rst;
  logic        clk_en;
  cplx_t       q;
  cplx_t       t;
  cplx_t       h;

  logic        exp_valid;
  logic [7:0]  exp_test;
  logic        exp_last;
  cplx_t       exp_h;

  int          pass_cnt;
  int          fail_cnt;
  int          pending_cnt;

  logic [19:0] vec_mem [0:max_vec*vec_words-1];
  int          num_vec;
  int          cycle_limit;
  int          cycle_cnt;

  cmplx_mult i_cmplx_mult (
    .clk    (clk),
    .rst    (rst),
    .clk_en (clk_en),
    .q      (q),
    .t      (t),
    .h      (h)
  );

  cmplx_checker i_checker (
    .clk         (clk),
    .rst         (rst),
    .clk_en      (clk_en),
    .q           (q),
    .t           (t),
    .h           (h),
    .exp_valid   (exp_valid),
    .exp_test    (exp_test),
    .exp_last    (exp_last),
    .exp_h       (exp_h),
    .pass_cnt    (pass_cnt),
    .fail_cnt    (fail_cnt),
    .pending_cnt (pending_cnt)
  );

  initial clk = 1'b0;
  always #10 clk = ~clk;

  // an unread entry still holds the fill with its top nibble set
  function automatic int count_vectors();
    int n;
    n = 0;
    while (n < max_vec && vec_mem[n*vec_words][19:16] != 4'hf) begin
      n++;
    end
    return n;
  endfunction

  task automatic drive_vector(input int idx);
    int base;
    base     = idx * vec_words;
    exp_test = vec_mem[base][7:0];
    q.re     = vec_mem[base + 1][17:0];
    q.im     = vec_mem[base + 2][17:0];
    t.re     = vec_mem[base + 3][17:0];
    t.im     = vec_mem[base + 4][17:0];
    clk_en   = vec_mem[base + 5][0];
    exp_h.re = vec_mem[base + 6][17:0];
    exp_h.im = vec_mem[base + 7][17:0];
    exp_valid = 1'b1;
    // last vector of a test when the next line starts another test
    exp_last = (idx == num_vec - 1) ||
               (vec_mem[base + vec_words][7:0] != exp_test);
  endtask

  task automatic drive_idle();
    q         = '0;
    t         = '0;
    exp_valid = 1'b0;
    exp_test  = '0;
    exp_last  = 1'b0;
    exp_h     = '0;
  endtask

  initial begin
    rst    = 1'b1;
    clk_en = 1'b0;
    drive_idle();
    // fill tagged with the address, never a valid test number
    for (int i = 0; i < max_vec * vec_words; i++) begin
      vec_mem[i] = 20'hf0000 | 20'(i);
    end
    $readmemh("bench/cmplx_testdata.hex", vec_mem);
    num_vec     = count_vectors();
    cycle_limit = 2 * num_vec + 50;

    // four rising edges with rst high
    repeat (4) @(negedge clk);
    rst = 1'b0;
    repeat (3) @(negedge clk);

    for (int i = 0; i < num_vec; i++) begin
      drive_vector(i);
      @(negedge clk);
    end

    // flush the last products out of the pipeline
    drive_idle();
    clk_en = 1'b1;
    repeat (pipe_depth + 2) @(negedge clk);

    if (num_vec == 0) begin
      $display("no test vectors were read from the data file");
    end
    if (pending_cnt != 0) begin
      $display("%0d expected results never came out of the DUT", pending_cnt);
    end
    $display("checks passed %0d, failed %0d", pass_cnt, fail_cnt);
    if (num_vec > 0 && fail_cnt == 0 && pending_cnt == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

  // limit follows from the number of vectors read
  initial begin
    cycle_cnt = 0;
    @(posedge clk);
    while (cycle_cnt < cycle_limit) begin
      @(posedge clk);
      cycle_cnt++;
    end
    $display("timeout, the run was stopped after %0d clock cycles", cycle_cnt);
    $display("TB FAILED");
    $finish;
  end

endmodule

/* bench/cmplx_testdata.hex */
// columns are test, q.re, q.im, t.re, t.im, clk_en, h.re, h.im
// samples are 18 bit two's complement in hex, lines with clk_en 0 are not accepted
// test 1 single products with zero vectors between them
01 00000 00000 00000 00000 1 00000 00000
01 10000 00000 10000 00000 1 04000 00000
01 00000 00000 00000 00000 1 00000 00000
01 10000 00000 00000 10000 1 00000 04000
01 00000 00000 00000 00000 1 00000 00000
01 00000 10000 00000 10000 1 3C000 00000
01 00000 00000 00000 00000 1 00000 00000
01 10000 00000 003E8 3F830 1 000FA 3FE0C
01 00000 00000 00000 00000 1 00000 00000
01 30000 10000 00BB8 003E8 1 3FC18 001F4
01 00000 00000 00000 00000 1 00000 00000
01 08000 3C000 3E000 01000 1 3FD00 00400
01 00000 00000 00000 00000 1 00000 00000
01 186A0 04E20 0C350 38AD0 1 05372 3E233
// test 2 exact halves of both signs and values just off a half
02 00002 00000 10000 00000 1 00001 00000
02 3FFFE 00000 10000 00000 1 00000 00000
02 00001 00000 1FFFF 00000 1 00000 00000
02 3FFFD 00000 0AAAB 00000 1 3FFFF 00000
02 10000 00000 00006 00000 1 00002 00000
02 10000 00000 3FFFA 00000 1 3FFFF 00000
02 10000 00000 00000 0000A 1 00000 00003
02 00000 10000 3FFF6 00000 1 00000 3FFFE
02 10000 10000 00005 00003 1 00001 00002
02 3FFFF 00001 0FFFF 10000 1 00000 00000
// test 3 back to back vectors
03 10000 00000 00190 3FCE0 1 00064 3FF38
03 00000 10000 00190 3FCE0 1 000C8 00064
03 30000 00000 0000C 00014 1 3FFFD 3FFFB
03 10000 00000 0000D 0000E 1 00003 00004
03 00000 30000 00001 00002 1 00001 00000
03 10000 10000 00064 00064 1 00000 00032
03 08000 00000 003E8 3FC18 1 0007D 3FF83
03 04000 04000 00320 3FCE0 1 00064 00000
// test 4 stalls, enable pattern from $random with seed 32'h4a8e34e1
04 10000 00000 00028 00050 1 0000A 00014
04 1FFFF 20001 0ABCD 35555 0 00000 00000
04 10000 00000 3FFD8 00078 1 3FFF6 0001E
04 00000 10000 00010 00008 1 3FFFE 00004
04 2AAAA 15555 1FFFF 20001 0 00000 00000
04 0F0F0 30F0F 12345 2DCBA 0 00000 00000
04 10000 00000 00002 3FFFE 1 00001 00000
04 3FFFF 00001 1FFFF 1FFFF 0 00000 00000
04 30000 00000 00064 3FF9C 1 3FFE7 00019
04 10000 10000 0002C 00004 1 0000A 0000C
04 10000 00000 00400 00800 1 00100 00200
04 1ABCD 25432 07777 38888 0 00000 00000
04 01234 3EDCB 1FFFF 00000 0 00000 00000
04 00000 30000 00024 3FFF4 1 3FFFD 3FFF7
// test 5 near full scale operands
05 1FFFF 00000 1FFFF 00000 1 0FFFF 00000
05 1FFFF 20001 1FFFF 1FFFF 1 1FFFE 00000
05 1FFFF 1FFFF 20001 1FFFF 1 20002 00000
05 1FFFF 1FFFF 1FFFF 1FFFF 1 00000 1FFFE
05 20001 20001 1FFFF 1FFFF 1 00000 20002
05 1FFFF 00000 20001 00000 1 30001 00000
05 1FFFF 10000 10000 20001 1 10000 34001

/* verilog.f */
source/cmul_pkg.sv
source/mac_stage.sv
source/half_product.sv
source/round_half_up.sv
source/cmplx_mult.sv
bench/cmplx_checker.sv
bench/tb_cmplx_mult.sv

/* run_sim.sh */
#!/bin/sh
# compile the complex multiplier testbench with Verilator and run it
# exit status is zero only when the testbench reports a pass

cd "$(dirname "$0")" || exit 1

verilator --binary --timing \
  --top-module tb_cmplx_mult \
  -f verilog.f
build_status=$?
if [ $build_status -ne 0 ]; then
  echo "verilator build failed with status $build_status"
  exit 1
fi

sim_out=$(./obj_dir/Vtb_cmplx_mult)
sim_status=$?
printf '%s\n' "$sim_out"
if [ $sim_status -ne 0 ]; then
  echo "simulation exited with status $sim_status"
  exit 1
fi

if printf '%s\n' "$sim_out" | grep -qx 'TB PASSED'; then
  echo "simulation passed"
  exit 0
fi

echo "simulation failed"
exit 1
